// File: common/decodePkg.sv
package decodePkg;

	localparam int aluOpWidth = 5;
	localparam int instrWidth = 32;
	localparam int funct3Width = 3;
	localparam int funct7Width = 7;
	localparam int mem2RegWidth = 2;
	localparam int origPcWidth = 2;

	// major opcodes of the RV32IM base groups
	localparam logic [6:0] opcLoad = 7'b0000011;
	localparam logic [6:0] opcOpImm = 7'b0010011;
	localparam logic [6:0] opcAuipc = 7'b0010111;
	localparam logic [6:0] opcStore = 7'b0100011;
	localparam logic [6:0] opcRType = 7'b0110011;
	localparam logic [6:0] opcLui = 7'b0110111;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcJalr = 7'b1100111;
	localparam logic [6:0] opcJal = 7'b1101111;

	// integer funct3
	localparam logic [funct3Width-1:0] funct3AddSub = 3'b000;
	localparam logic [funct3Width-1:0] funct3Sll = 3'b001;
	localparam logic [funct3Width-1:0] funct3Slt = 3'b010;
	localparam logic [funct3Width-1:0] funct3Sltu = 3'b011;
	localparam logic [funct3Width-1:0] funct3Xor = 3'b100;
	localparam logic [funct3Width-1:0] funct3SrlSra = 3'b101;
	localparam logic [funct3Width-1:0] funct3Or = 3'b110;
	localparam logic [funct3Width-1:0] funct3And = 3'b111;

	// M extension funct3
	localparam logic [funct3Width-1:0] funct3Mul = 3'b000;
	localparam logic [funct3Width-1:0] funct3Mulh = 3'b001;
	localparam logic [funct3Width-1:0] funct3Mulhsu = 3'b010;
	localparam logic [funct3Width-1:0] funct3Mulhu = 3'b011;
	localparam logic [funct3Width-1:0] funct3Div = 3'b100;
	localparam logic [funct3Width-1:0] funct3Divu = 3'b101;
	localparam logic [funct3Width-1:0] funct3Rem = 3'b110;
	localparam logic [funct3Width-1:0] funct3Remu = 3'b111;

	localparam logic [funct7Width-1:0] funct7Base = 7'b0000000;
	localparam logic [funct7Width-1:0] funct7Alt = 7'b0100000;
	localparam logic [funct7Width-1:0] funct7MulDiv = 7'b0000001;

	// ALU operation codes seen by the execute stage
	localparam logic [aluOpWidth-1:0] aluAnd = 5'd0;
	localparam logic [aluOpWidth-1:0] aluOr = 5'd1;
	localparam logic [aluOpWidth-1:0] aluXor = 5'd2;
	localparam logic [aluOpWidth-1:0] aluAdd = 5'd3;
	localparam logic [aluOpWidth-1:0] aluSub = 5'd4;
	localparam logic [aluOpWidth-1:0] aluSlt = 5'd5;
	localparam logic [aluOpWidth-1:0] aluSltu = 5'd6;
	localparam logic [aluOpWidth-1:0] aluSll = 5'd7;
	localparam logic [aluOpWidth-1:0] aluSrl = 5'd8;
	localparam logic [aluOpWidth-1:0] aluSra = 5'd9;
	localparam logic [aluOpWidth-1:0] aluLui = 5'd10;
	localparam logic [aluOpWidth-1:0] aluMul = 5'd11;
	localparam logic [aluOpWidth-1:0] aluMulh = 5'd12;
	localparam logic [aluOpWidth-1:0] aluMulhsu = 5'd13;
	localparam logic [aluOpWidth-1:0] aluMulhu = 5'd14;
	localparam logic [aluOpWidth-1:0] aluDiv = 5'd15;
	localparam logic [aluOpWidth-1:0] aluDivu = 5'd16;
	localparam logic [aluOpWidth-1:0] aluRem = 5'd17;
	localparam logic [aluOpWidth-1:0] aluRemu = 5'd18;
	localparam logic [aluOpWidth-1:0] aluNull = 5'd31;

	typedef enum logic [3:0] {
		clsLoad,
		clsOpImm,
		clsAuipc,
		clsStore,
		clsRType,
		clsLui,
		clsBranch,
		clsJalr,
		clsJal,
		clsIllegal
	} instrClass;

	// same word in register format or immediate format
	typedef union packed {
		struct packed {
			logic [funct7Width-1:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [funct3Width-1:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [funct3Width-1:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
	} instrWord;

endpackage

// File: common/stageIf.sv
`timescale 1ns/1ps

// classStage to aluOpStage
interface classIf;
	logic valid;
	logic ready;
	decodePkg::instrClass cls;
	logic [decodePkg::funct3Width-1:0] funct3;
	logic [decodePkg::funct7Width-1:0] funct7;

	modport src (
		output valid,
		output cls,
		output funct3,
		output funct7,
		input ready
	);

	modport dst (
		input valid,
		input cls,
		input funct3,
		input funct7,
		output ready
	);
endinterface

// aluOpStage to ctrlStage
interface opIf;
	logic valid;
	logic ready;
	decodePkg::instrClass cls;
	logic [decodePkg::aluOpWidth-1:0] aluOp;

	modport src (
		output valid,
		output cls,
		output aluOp,
		input ready
	);

	modport dst (
		input valid,
		input cls,
		input aluOp,
		output ready
	);
endinterface

// File: design/aluOpStage.sv
`timescale 1ns/1ps

module aluOpStage (
	input logic clk,
	input logic rst,
	classIf.dst in,
	opIf.src out
);

	decodePkg::instrClass nextCls;
	logic [decodePkg::aluOpWidth-1:0] nextOp;

	// shared by op-imm and reg-reg but sub only exists in reg-reg
	function automatic logic [decodePkg::aluOpWidth-1:0] baseOp(
		input logic [decodePkg::funct3Width-1:0] f3,
		input logic alt,
		input logic subOk
	);
		case (f3)
			decodePkg::funct3AddSub:
				baseOp = (alt && subOk) ? decodePkg::aluSub : decodePkg::aluAdd;
			decodePkg::funct3Sll: baseOp = decodePkg::aluSll;
			decodePkg::funct3Slt: baseOp = decodePkg::aluSlt;
			decodePkg::funct3Sltu: baseOp = decodePkg::aluSltu;
			decodePkg::funct3Xor: baseOp = decodePkg::aluXor;
			decodePkg::funct3SrlSra:
				baseOp = alt ? decodePkg::aluSra : decodePkg::aluSrl;
			decodePkg::funct3Or: baseOp = decodePkg::aluOr;
			default: baseOp = decodePkg::aluAnd;
		endcase
	endfunction

	function automatic logic [decodePkg::aluOpWidth-1:0] mulDivOp(
		input logic [decodePkg::funct3Width-1:0] f3
	);
		case (f3)
			decodePkg::funct3Mul: mulDivOp = decodePkg::aluMul;
			decodePkg::funct3Mulh: mulDivOp = decodePkg::aluMulh;
			decodePkg::funct3Mulhsu: mulDivOp = decodePkg::aluMulhsu;
			decodePkg::funct3Mulhu: mulDivOp = decodePkg::aluMulhu;
			decodePkg::funct3Div: mulDivOp = decodePkg::aluDiv;
			decodePkg::funct3Divu: mulDivOp = decodePkg::aluDivu;
			decodePkg::funct3Rem: mulDivOp = decodePkg::aluRem;
			default: mulDivOp = decodePkg::aluRemu;
		endcase
	endfunction

	assign in.ready = !out.valid || out.ready;

	always_comb
	begin
		nextCls = in.cls;
		// address math for memory, branches and jumps
		nextOp = decodePkg::aluAdd;
		case (in.cls)
			decodePkg::clsLui: nextOp = decodePkg::aluLui;
			decodePkg::clsOpImm:
				nextOp = baseOp(in.funct3, in.funct7 == decodePkg::funct7Alt, 1'b0);
			decodePkg::clsRType:
			begin
				if (in.funct7 == decodePkg::funct7MulDiv)
					nextOp = mulDivOp(in.funct3);
				else if (in.funct7 == decodePkg::funct7Base || in.funct7 == decodePkg::funct7Alt)
					nextOp = baseOp(in.funct3, in.funct7 == decodePkg::funct7Alt, 1'b1);
				else
				begin
					// unknown funct7 demotes the whole instruction
					nextCls = decodePkg::clsIllegal;
					nextOp = decodePkg::aluNull;
				end
			end
			decodePkg::clsIllegal: nextOp = decodePkg::aluNull;
			default: nextOp = decodePkg::aluAdd;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out.valid <= 1'b0;
		else if (in.ready)
			out.valid <= in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (in.valid && in.ready)
		begin
			out.cls <= nextCls;
			out.aluOp <= nextOp;
		end
	end

	// illegal from either stage carries the null op and nothing else does
	nullOnIllegal: assert property (@(posedge clk) disable iff (rst)
		out.valid |-> ((out.aluOp == decodePkg::aluNull) == (out.cls == decodePkg::clsIllegal)));

endmodule

// File: design/classStage.sv
`timescale 1ns/1ps

module classStage (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input decodePkg::instrWord instr,
	classIf.src out
);

	decodePkg::instrClass nextCls;
	logic [decodePkg::funct7Width-1:0] nextFunct7;

	// empty slot or draining downstream
	assign inReady = !out.valid || out.ready;

	always_comb
	begin
		case (instr.r.opcode)
			decodePkg::opcLoad: nextCls = decodePkg::clsLoad;
			decodePkg::opcOpImm: nextCls = decodePkg::clsOpImm;
			decodePkg::opcAuipc: nextCls = decodePkg::clsAuipc;
			decodePkg::opcStore: nextCls = decodePkg::clsStore;
			decodePkg::opcRType: nextCls = decodePkg::clsRType;
			decodePkg::opcLui: nextCls = decodePkg::clsLui;
			decodePkg::opcBranch: nextCls = decodePkg::clsBranch;
			decodePkg::opcJalr: nextCls = decodePkg::clsJalr;
			decodePkg::opcJal: nextCls = decodePkg::clsJal;
			default: nextCls = decodePkg::clsIllegal;
		endcase
	end

	always_comb
	begin
		case (nextCls)
			decodePkg::clsRType: nextFunct7 = instr.r.funct7;
			// upper imm bits pick srli or srai
			decodePkg::clsOpImm: nextFunct7 = instr.i.imm[11:5];
			default: nextFunct7 = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out.valid <= 1'b0;
		else if (inReady)
			out.valid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
		begin
			out.cls <= nextCls;
			out.funct3 <= instr.r.funct3;
			out.funct7 <= nextFunct7;
		end
	end

	// a stalled item must not change before aluOpStage takes it
	stallHold: assert property (@(posedge clk) disable iff (rst)
		out.valid && !out.ready |=> out.valid && $stable(out.cls)
			&& $stable(out.funct3) && $stable(out.funct7));

endmodule

// File: design/ctrlStage.sv
`timescale 1ns/1ps

module ctrlStage (
	input logic clk,
	input logic rst,
	opIf.dst in,
	output logic ctrlValid,
	input logic ctrlReady,
	output logic origA,
	output logic origB,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output logic [decodePkg::mem2RegWidth-1:0] mem2Reg,
	output logic [decodePkg::origPcWidth-1:0] origPc,
	output logic [decodePkg::aluOpWidth-1:0] aluControl
);

	// origA origB regWrite memWrite memRead mem2Reg origPc
	logic [8:0] nextCtrl;

	assign in.ready = !ctrlValid || ctrlReady;

	always_comb
	begin
		case (in.cls)
			decodePkg::clsLoad:
				nextCtrl = {1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 2'd2, 2'd0};
			decodePkg::clsOpImm:
				nextCtrl = {1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0};
			// pc as operand A
			decodePkg::clsAuipc:
				nextCtrl = {1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0};
			decodePkg::clsStore:
				nextCtrl = {1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0};
			decodePkg::clsRType:
				nextCtrl = {1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0};
			decodePkg::clsLui:
				nextCtrl = {1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0};
			decodePkg::clsBranch:
				nextCtrl = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd1};
			// link value pc+4 goes to rd
			decodePkg::clsJalr:
				nextCtrl = {1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd1, 2'd3};
			decodePkg::clsJal:
				nextCtrl = {1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd1, 2'd2};
			default:
				nextCtrl = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			ctrlValid <= 1'b0;
		else if (in.ready)
			ctrlValid <= in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (in.valid && in.ready)
		begin
			{origA, origB, regWrite, memWrite, memRead, mem2Reg, origPc} <= nextCtrl;
			aluControl <= in.aluOp;
		end
	end

	// load and store never share a cycle on the data port
	noMemConflict: assert property (@(posedge clk) disable iff (rst)
		ctrlValid |-> !(memWrite && memRead));

endmodule

// File: design/decoderTop.sv
`timescale 1ns/1ps

module decoderTop (
	input logic clk,
	input logic rst,
	input logic instrValid,
	output logic instrReady,
	input logic [decodePkg::instrWidth-1:0] instr,
	output logic ctrlValid,
	input logic ctrlReady,
	output logic origA,
	output logic origB,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output logic [decodePkg::mem2RegWidth-1:0] mem2Reg,
	output logic [decodePkg::origPcWidth-1:0] origPc,
	output logic [decodePkg::aluOpWidth-1:0] aluControl
);

	classIf classBus ();
	opIf opBus ();

	// opcode to class
	classStage uClass (
		.clk(clk),
		.rst(rst),
		.inValid(instrValid),
		.inReady(instrReady),
		.instr(decodePkg::instrWord'(instr)),
		.out(classBus.src)
	);

	// funct fields to ALU op
	aluOpStage uAluOp (
		.clk(clk),
		.rst(rst),
		.in(classBus.dst),
		.out(opBus.src)
	);

	// class to control word
	ctrlStage uCtrl (
		.clk(clk),
		.rst(rst),
		.in(opBus.dst),
		.ctrlValid(ctrlValid),
		.ctrlReady(ctrlReady),
		.origA(origA),
		.origB(origB),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.memRead(memRead),
		.mem2Reg(mem2Reg),
		.origPc(origPc),
		.aluControl(aluControl)
	);

endmodule

// File: dv/decoderVectors.svh
`ifndef DECODER_VECTORS_SVH
`define DECODER_VECTORS_SVH

localparam int numRows = 37;

// instruction word, then origA origB regWrite memWrite memRead mem2Reg origPc, then aluControl
localparam logic [45:0] vecTable [numRows] = '{
	// one per non-arithmetic class
	{12'h004, 5'd1, 3'b010, 5'd5, 7'b0000011, 9'b0_1_1_0_1_10_00, 5'd3},
	{7'b0000000, 5'd6, 5'd2, 3'b010, 5'd8, 7'b0100011, 9'b0_1_0_1_0_00_00, 5'd3},
	{20'h12345, 5'd7, 7'b0010111, 9'b1_1_1_0_0_00_00, 5'd3},
	{20'habcde, 5'd9, 7'b0110111, 9'b0_1_1_0_0_00_00, 5'd10},
	{7'b0000000, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011, 9'b0_0_0_0_0_00_01, 5'd3},
	{12'h010, 5'd1, 3'b000, 5'd1, 7'b1100111, 9'b0_0_1_0_0_01_11, 5'd3},
	{20'h00100, 5'd1, 7'b1101111, 9'b0_0_1_0_0_01_10, 5'd3},
	// register-register
	{7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd3},
	{7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd4},
	{7'b0000000, 5'd2, 5'd1, 3'b001, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd7},
	{7'b0100000, 5'd2, 5'd1, 3'b001, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd7},
	{7'b0000000, 5'd2, 5'd1, 3'b010, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd5},
	{7'b0000000, 5'd2, 5'd1, 3'b011, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd6},
	{7'b0000000, 5'd2, 5'd1, 3'b100, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd2},
	{7'b0000000, 5'd2, 5'd1, 3'b101, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd8},
	{7'b0100000, 5'd2, 5'd1, 3'b101, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd9},
	{7'b0000000, 5'd2, 5'd1, 3'b110, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd1},
	{7'b0000000, 5'd2, 5'd1, 3'b111, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd0},
	// op-immediate
	// addi with imm[10] set must stay add
	{12'h400, 5'd1, 3'b000, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd3},
	{12'h003, 5'd1, 3'b001, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd7},
	{12'hfff, 5'd1, 3'b010, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd5},
	{12'h001, 5'd1, 3'b011, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd6},
	{12'h0ff, 5'd1, 3'b100, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd2},
	{12'h004, 5'd1, 3'b101, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd8},
	{12'h404, 5'd1, 3'b101, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd9},
	{12'h0f0, 5'd1, 3'b110, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd1},
	{12'h00f, 5'd1, 3'b111, 5'd4, 7'b0010011, 9'b0_1_1_0_0_00_00, 5'd0},
	// multiply and divide
	{7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd11},
	{7'b0000001, 5'd2, 5'd1, 3'b001, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd12},
	{7'b0000001, 5'd2, 5'd1, 3'b010, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd13},
	{7'b0000001, 5'd2, 5'd1, 3'b011, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd14},
	{7'b0000001, 5'd2, 5'd1, 3'b100, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd15},
	{7'b0000001, 5'd2, 5'd1, 3'b101, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd16},
	{7'b0000001, 5'd2, 5'd1, 3'b110, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd17},
	{7'b0000001, 5'd2, 5'd1, 3'b111, 5'd3, 7'b0110011, 9'b0_0_1_0_0_00_00, 5'd18},
	// unknown opcode, then unknown funct7
	{12'h000, 5'd1, 3'b000, 5'd2, 7'b1111111, 9'b0_0_0_0_0_00_00, 5'd31},
	{7'b0000010, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011, 9'b0_0_0_0_0_00_00, 5'd31}
};

`endif

// File: dv/decoderTb.sv
`timescale 1ns/1ps

module decoderTb;

	`include "decoderVectors.svh"

	localparam int idxBits = $clog2(numRows);
	localparam int cycleLimit = 20 * numRows + 100;

	logic clk = 1'b0;
	logic rst;
	logic instrValid;
	logic instrReady;
	logic [31:0] instr;
	logic ctrlValid;
	logic ctrlReady = 1'b1;
	// origA origB regWrite memWrite memRead mem2Reg origPc aluControl
	logic [13:0] outWord;

	int seed = 22517;
	int rnd;
	logic randomReady = 1'b0;
	int cycle = 0;
	int acceptCycle = -1;
	int outCount = 0;
	logic [idxBits-1:0] outRow = '0;
	logic stalled = 1'b0;
	logic [13:0] heldOut;
	logic [45:0] expRow;

	decoderTop dut (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.instr(instr),
		.ctrlValid(ctrlValid),
		.ctrlReady(ctrlReady),
		.origA(outWord[13]),
		.origB(outWord[12]),
		.regWrite(outWord[11]),
		.memWrite(outWord[10]),
		.memRead(outWord[9]),
		.mem2Reg(outWord[8:7]),
		.origPc(outWord[6:5]),
		.aluControl(outWord[4:0])
	);

	initial
		forever #4 clk = ~clk;

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// hold the row until the first stage takes it
	task automatic sendRow(input logic [idxBits-1:0] idx);
		@(negedge clk);
		instrValid = 1'b1;
		instr = vecTable[idx][45:14];
		@(posedge clk);
		while (!instrReady)
			@(posedge clk);
		if (acceptCycle < 0)
			acceptCycle = cycle;
	endtask

	always @(negedge clk)
	begin
		rnd = $random(seed);
		ctrlReady = randomReady ? rnd[0] : 1'b1;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit)
		begin
			$display("Timeout after %0d cycles with %0d outputs seen", cycle, outCount);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// in-order checker
	always @(posedge clk)
	begin
		if (stalled)
		begin
			checkVal("ctrlValid", 32'(ctrlValid), 32'd1);
			checkVal("stalled outputs", 32'(outWord), 32'(heldOut));
		end
		stalled = ctrlValid && !ctrlReady;
		heldOut = outWord;
		if (ctrlValid && ctrlReady)
		begin
			if (outCount >= 2 * numRows)
			begin
				$display("An extra control word came out after the last row at %0d ns", $time);
				$display("Test failed");
				$fatal(1, "extra output");
			end
			else
			begin
				expRow = vecTable[outRow];
				if (outCount == 0)
					checkVal("latency", 32'(cycle - acceptCycle), 32'd3);
				checkVal("origA", 32'(outWord[13]), 32'(expRow[13]));
				checkVal("origB", 32'(outWord[12]), 32'(expRow[12]));
				checkVal("regWrite", 32'(outWord[11]), 32'(expRow[11]));
				checkVal("memWrite", 32'(outWord[10]), 32'(expRow[10]));
				checkVal("memRead", 32'(outWord[9]), 32'(expRow[9]));
				checkVal("mem2Reg", 32'(outWord[8:7]), 32'(expRow[8:7]));
				checkVal("origPc", 32'(outWord[6:5]), 32'(expRow[6:5]));
				checkVal("aluControl", 32'(outWord[4:0]), 32'(expRow[4:0]));
				outCount++;
				outRow = (outRow == idxBits'(numRows - 1)) ? '0 : outRow + 1'b1;
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkVal("ctrlValid", 32'(ctrlValid), 32'd0);
		checkVal("instrReady", 32'(instrReady), 32'd1);
		for (int r = 0; r < numRows; r++)
			sendRow(idxBits'(r));
		// replay with a stalling sink
		randomReady = 1'b1;
		for (int r = 0; r < numRows; r++)
			sendRow(idxBits'(r));
		@(negedge clk);
		instrValid = 1'b0;
		wait (outCount == 2 * numRows);
		repeat (4) @(posedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+dv
common/decodePkg.sv
common/stageIf.sv
design/classStage.sv
design/aluOpStage.sv
design/ctrlStage.sv
design/decoderTop.sv
dv/decoderTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module decoderTb -o decoderSim
# the log decides the result, not the simulator's exit code
./obj_dir/decoderSim | tee sim.log || true
if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
